/* design/gfx_defs.svh */
/* width and size macros shared by the rasteriser sources
   include in any file that needs a coordinate width or the scene size */
`ifndef GFX_DEFS_SVH
`define GFX_DEFS_SVH

// signed screen coordinate bits
`define GFX_CORDW 16

// palette colour index bits
`define GFX_CIDXW 4

// shapes drawn for one castle scene
`define SCENE_SHAPES 16

`endif

/* design/gfx_types_pkg.sv */
/* screen-space types for drawers, sequencer and top level
   import where points or output pixels are handled */
`include "gfx_defs.svh"

package gfx_types_pkg;

    typedef logic signed [`GFX_CORDW-1:0] coord_t;  // signed screen position
    typedef logic [`GFX_CIDXW-1:0] cidx_t;           // palette entry

    // drawer output, one position on screen
    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // top-level output record
    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } pixel_t;

endpackage

/* design/draw_cmd_pkg.sv */
/* drawing command types: shape kind and the record of one table entry
   used by the sequencer shape table */
package draw_cmd_pkg;

    import gfx_types_pkg::*;

    typedef enum logic {
        RECT,    // filled box, x0/y0 to x1/y1
        CIRCLE   // filled disc, centre x0/y0, radius r
    } shape_kind_e;

    // one shape of the scene, unscaled
    typedef struct packed {
        shape_kind_e kind;
        coord_t      x0;    // corner or centre
        coord_t      y0;
        coord_t      x1;    // far corner, rect only
        coord_t      y1;
        coord_t      r;     // radius, circle only
        cidx_t       cidx;
    } draw_cmd_t;

endpackage

/* design/draw_rect_fill.sv */
/* filled rectangle drawer, walks an inclusive box in raster order
   pulse start with p0 above-left of p1, then drain pt with pt_ready */
`timescale 1ns/1ps

module draw_rect_fill (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  gfx_types_pkg::point_t p0,
    input  gfx_types_pkg::point_t p1,
    output gfx_types_pkg::point_t pt,
    output logic                  pt_valid,
    input  logic                  pt_ready,
    output logic                  busy,
    output logic                  done
);
    import gfx_types_pkg::*;

    coord_t x_start;   // left edge, reloaded every row
    point_t corner;    // bottom-right corner
    logic   launch;
    logic   accept;
    logic   last_col;
    logic   last_pt;

    assign launch   = start && !busy;
    assign accept   = pt_valid && pt_ready;
    assign last_col = (pt.x == corner.x);
    assign last_pt  = last_col && (pt.y == corner.y);

    // every box position is drawn, so busy is the valid flag
    assign busy = pt_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            pt_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (launch) begin
                pt_valid <= 1'b1;  // first point is p0
            end else if (accept && last_pt) begin
                pt_valid <= 1'b0;
                done     <= 1'b1;
            end
        end
    end

    // position walk, moves only on an accepted point
    always_ff @(posedge clk) begin
        if (launch) begin
            pt      <= p0;
            x_start <= p0.x;
            corner  <= p1;
        end else if (accept && !last_pt) begin
            if (last_col) begin
                pt.x <= x_start;              // wrap to next row
                pt.y <= pt.y + coord_t'(1);
            end else begin
                pt.x <= pt.x + coord_t'(1);
            end
        end
    end

endmodule

/* design/draw_circle_fill.sv */
/* filled circle drawer, scans the bounding box one position per cycle
   and presents the positions inside the radius, in raster order */
`timescale 1ns/1ps

module draw_circle_fill (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  gfx_types_pkg::point_t c,
    input  gfx_types_pkg::coord_t r,
    output gfx_types_pkg::point_t pt,
    output logic                  pt_valid,
    input  logic                  pt_ready,
    output logic                  busy,
    output logic                  done
);
    import gfx_types_pkg::*;

    localparam int SQW = 2 * $bits(coord_t) + 1;  // room for dx^2 + dy^2
    typedef logic signed [SQW-1:0] sq_t;

    point_t c_q;         // latched centre
    coord_t r_q;         // latched radius
    sq_t    r2;          // radius squared
    coord_t dx;          // scan position, relative to centre
    coord_t dy;
    logic   scan_on;     // scan positions left
    logic   s1_valid;    // test stage holds a position
    coord_t s1_dx;
    coord_t s1_dy;
    sq_t    s1_sq;       // registered sum of squares
    sq_t    dx_w;
    sq_t    dy_w;
    sq_t    r_w;
    logic   launch;
    logic   adv;

    assign launch = start && !busy;
    assign adv    = !pt_valid || pt_ready;  // output slot free, pipeline moves

    assign dx_w = sq_t'(dx);
    assign dy_w = sq_t'(dy);
    assign r_w  = sq_t'(r);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            scan_on  <= 1'b0;
            s1_valid <= 1'b0;
            pt_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (launch) begin
                busy     <= 1'b1;
                scan_on  <= 1'b1;
                s1_valid <= 1'b0;
            end else if (busy && adv) begin
                pt_valid <= s1_valid && (s1_sq <= r2);  // inside test
                s1_valid <= scan_on;
                if (scan_on && dx == r_q && dy == r_q) begin
                    scan_on <= 1'b0;  // last box position issued
                end
                // scan and test stage empty, output drained this cycle
                if (!scan_on && !s1_valid) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            c_q <= c;
            r_q <= r;
            r2  <= r_w * r_w;
            dx  <= -r;  // top-left of bounding box
            dy  <= -r;
        end else if (busy && adv) begin
            pt.x  <= c_q.x + s1_dx;
            pt.y  <= c_q.y + s1_dy;
            s1_dx <= dx;
            s1_dy <= dy;
            s1_sq <= dx_w * dx_w + dy_w * dy_w;
            if (scan_on) begin
                if (dx == r_q) begin
                    dx <= -r_q;
                    dy <= dy + coord_t'(1);
                end else begin
                    dx <= dx + coord_t'(1);
                end
            end
        end
    end

endmodule

/* design/scene_sequencer.sv */
/* castle scene sequencer: steps through the shape table, starts one drawer
   per shape and merges its points with the shape colour into the pixel stream */
`timescale 1ns/1ps
`include "gfx_defs.svh"

module scene_sequencer #(
    parameter int SCALE = 1  // 1, 2 or 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    output logic                  rect_start,
    output gfx_types_pkg::point_t rect_p0,
    output gfx_types_pkg::point_t rect_p1,
    output logic                  circ_start,
    output gfx_types_pkg::point_t circ_c,
    output gfx_types_pkg::coord_t circ_r,
    input  gfx_types_pkg::point_t rect_pt,
    input  gfx_types_pkg::point_t circ_pt,
    input  logic                  rect_pt_valid,
    input  logic                  circ_pt_valid,
    output logic                  rect_pt_ready,
    output logic                  circ_pt_ready,
    input  logic                  rect_busy,
    input  logic                  circ_busy,
    input  logic                  rect_done,
    input  logic                  circ_done,
    output gfx_types_pkg::pixel_t pix,
    output logic                  pix_valid,
    input  logic                  pix_ready,
    output logic                  busy,
    output logic                  done
);
    import gfx_types_pkg::*;
    import draw_cmd_pkg::*;

    localparam int IDW = $clog2(`SCENE_SHAPES);

    typedef enum logic [1:0] {IDLE, LOAD, DRAW, FINISH} seq_state_e;

    seq_state_e     state;
    logic [IDW-1:0] shape_id;
    draw_cmd_t      cur_cmd;     // table entry for shape_id
    shape_kind_e    cur_kind;
    cidx_t          cur_cidx;    // colour of the shape being drawn
    point_t         geo_p0;      // scaled corner or centre
    point_t         geo_p1;
    coord_t         geo_r;
    logic           shape_done;

    function automatic draw_cmd_t rect_cmd(input int x0, input int y0, input int x1,
                                           input int y1, input int ci);
        return '{kind: RECT, x0: coord_t'(x0), y0: coord_t'(y0), x1: coord_t'(x1),
                 y1: coord_t'(y1), r: '0, cidx: cidx_t'(ci)};
    endfunction

    function automatic draw_cmd_t circ_cmd(input int x0, input int y0, input int rad,
                                           input int ci);
        return '{kind: CIRCLE, x0: coord_t'(x0), y0: coord_t'(y0), x1: '0, y1: '0,
                 r: coord_t'(rad), cidx: cidx_t'(ci)};
    endfunction

    // castle at 320x180, colours from a pico8 style palette
    function automatic draw_cmd_t scene_cmd(input logic [IDW-1:0] id);
        case (id)
            4'd0:    return rect_cmd( 60,  70, 190, 120, 5);  // main building
            4'd1:    return rect_cmd(110, 100, 140, 120, 4);  // drawbridge
            4'd2:    return circ_cmd(125, 100,  15, 4);       // drawbridge arch
            4'd3:    return rect_cmd( 40,  45,  60, 120, 5);  // left tower
            4'd4:    return rect_cmd(110,  40, 140,  70, 5);  // middle tower
            4'd5:    return rect_cmd(190,  45, 210, 120, 5);  // right tower
            4'd6:    return rect_cmd( 46,  50,  54,  65, 1);  // left window
            4'd7:    return rect_cmd(120,  45, 130,  65, 1);  // middle window
            4'd8:    return rect_cmd(196,  50, 204,  65, 1);  // right window
            4'd9:    return rect_cmd( 63,  62,  72,  70, 5);  // battlements
            4'd10:   return rect_cmd( 80,  62,  89,  70, 5);
            4'd11:   return rect_cmd( 97,  62, 106,  70, 5);
            4'd12:   return rect_cmd(144,  62, 153,  70, 5);
            4'd13:   return rect_cmd(161,  62, 170,  70, 5);
            4'd14:   return rect_cmd(178,  62, 187,  70, 5);
            default: return circ_cmd(275,  38,  20, 9);       // sun, orange
        endcase
    endfunction

    function automatic coord_t scale(input coord_t v);
        return coord_t'(v * SCALE);
    endfunction

    assign cur_cmd    = scene_cmd(shape_id);
    assign shape_done = (cur_kind == CIRCLE) ? circ_done : rect_done;
    assign busy       = (state != IDLE);
    assign done       = (state == FINISH);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            shape_id   <= '0;
            rect_start <= 1'b0;
            circ_start <= 1'b0;
        end else begin
            rect_start <= 1'b0;
            circ_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        shape_id <= '0;
                        state    <= LOAD;
                    end
                end
                LOAD: begin
                    rect_start <= (cur_cmd.kind == RECT);
                    circ_start <= (cur_cmd.kind == CIRCLE);
                    state      <= DRAW;
                end
                DRAW: begin
                    if (shape_done) begin
                        if (shape_id == IDW'(`SCENE_SHAPES - 1)) begin
                            state <= FINISH;
                        end else begin
                            shape_id <= shape_id + 1'b1;
                            state    <= LOAD;
                        end
                    end
                end
                default: state <= IDLE;  // FINISH
            endcase
        end
    end

    // scaled geometry and colour for the drawer about to start
    always_ff @(posedge clk) begin
        if (state == LOAD) begin
            geo_p0   <= '{x: scale(cur_cmd.x0), y: scale(cur_cmd.y0)};
            geo_p1   <= '{x: scale(cur_cmd.x1), y: scale(cur_cmd.y1)};
            geo_r    <= scale(cur_cmd.r);
            cur_kind <= cur_cmd.kind;
            cur_cidx <= cur_cmd.cidx;
        end
    end

    assign rect_p0 = geo_p0;
    assign rect_p1 = geo_p1;
    assign circ_c  = geo_p0;
    assign circ_r  = geo_r;

    // merge: the busy drawer owns the output stream
    always_comb begin
        if (circ_busy) begin
            pix       = '{x: circ_pt.x, y: circ_pt.y, cidx: cur_cidx};
            pix_valid = circ_pt_valid;
        end else begin
            pix       = '{x: rect_pt.x, y: rect_pt.y, cidx: cur_cidx};
            pix_valid = rect_busy && rect_pt_valid;
        end
    end

    assign circ_pt_ready = circ_busy && pix_ready;
    assign rect_pt_ready = rect_busy && pix_ready;

endmodule

/* design/scene_renderer.sv */
/* castle scene rasteriser top level, a start pulse draws the whole scene
   as a pixel stream with back-pressure and ends with a one-cycle done */
`timescale 1ns/1ps

module scene_renderer #(
    parameter int SCALE = 1  // 1 gives 320x180, 2 and 4 scale up
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    output gfx_types_pkg::pixel_t pix,
    output logic                  pix_valid,
    input  logic                  pix_ready,
    output logic                  busy,
    output logic                  done
);
    import gfx_types_pkg::*;

    logic   rect_start, rect_pt_valid, rect_pt_ready, rect_busy, rect_done;
    logic   circ_start, circ_pt_valid, circ_pt_ready, circ_busy, circ_done;
    point_t rect_p0, rect_p1, rect_pt;
    point_t circ_c, circ_pt;
    coord_t circ_r;

    scene_sequencer #(.SCALE(SCALE)) u_seq (
        .clk, .rst, .start,
        .rect_start, .rect_p0, .rect_p1,
        .circ_start, .circ_c, .circ_r,
        .rect_pt, .circ_pt,
        .rect_pt_valid, .circ_pt_valid,
        .rect_pt_ready, .circ_pt_ready,
        .rect_busy, .circ_busy, .rect_done, .circ_done,
        .pix, .pix_valid, .pix_ready,
        .busy, .done
    );

    draw_rect_fill u_rect (
        .clk, .rst,
        .start(rect_start), .p0(rect_p0), .p1(rect_p1),
        .pt(rect_pt), .pt_valid(rect_pt_valid), .pt_ready(rect_pt_ready),
        .busy(rect_busy), .done(rect_done)
    );

    draw_circle_fill u_circ (
        .clk, .rst,
        .start(circ_start), .c(circ_c), .r(circ_r),
        .pt(circ_pt), .pt_valid(circ_pt_valid), .pt_ready(circ_pt_ready),
        .busy(circ_busy), .done(circ_done)
    );

endmodule

/* test/scene_renderer_asserts.sv */
/* concurrent checks on the renderer pixel stream and done pulse,
   bound into every scene_renderer instance */
`timescale 1ns/1ps

module scene_renderer_asserts (
    input logic                  clk,
    input logic                  rst,
    input gfx_types_pkg::pixel_t pix,
    input logic                  pix_valid,
    input logic                  pix_ready,
    input logic                  busy,
    input logic                  done
);

    int fail_count = 0;  // assertion failures seen so far

    // stalled pixel stays offered with the same value
    a_pix_stable: assert property (@(posedge clk) disable iff (rst)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix))
        else begin
            $error("pix or pix_valid changed while stalled");
            fail_count++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done high for more than one cycle");
            fail_count++;
        end

    a_valid_busy: assert property (@(posedge clk) disable iff (rst) !busy |-> !pix_valid)
        else begin
            $error("pix_valid high while not busy");
            fail_count++;
        end

    a_reset_quiet: assert property (@(posedge clk) rst |=> !pix_valid && !busy && !done)
        else begin
            $error("output active in the cycle after reset");
            fail_count++;
        end

endmodule

bind scene_renderer scene_renderer_asserts u_asserts (
    .clk(clk), .rst(rst), .pix(pix), .pix_valid(pix_valid),
    .pix_ready(pix_ready), .busy(busy), .done(done)
);

/* test/tb_scene_renderer.sv */
/* directed testbench for the castle scene rasteriser, checks every pixel
   against a reference scene model built from its own shape table */
`timescale 1ns/1ps
`include "gfx_defs.svh"

module tb_scene_renderer;
    import gfx_types_pkg::*;
    import draw_cmd_pkg::*;

    localparam int TIMEOUT = 200000;  // cycles allowed for one scene

    logic   clk = 1'b0;
    logic   rst;
    logic   start;
    logic   pix_ready;
    pixel_t pix;
    logic   pix_valid;
    logic   busy;
    logic   done;

    draw_cmd_t scene [`SCENE_SHAPES];
    int        n_shapes = 0;
    pixel_t    exp_q [$];  // expected pixel stream of one scene
    int        sun_seen;   // pixels with the sun colour in the last run

    scene_renderer #(.SCALE(1)) dut (
        .clk, .rst, .start, .pix, .pix_valid, .pix_ready, .busy, .done
    );

    always #2 clk = ~clk;  // 4 ns period

    task automatic fail_run();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got (%0d,%0d,%0d), expected (%0d,%0d,%0d)",
                     $time, name, got.x, got.y, got.cidx, exp.x, exp.y, exp.cidx);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got %b, expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_idle();
        check_bit("pix_valid", pix_valid, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
    endtask

    task automatic add_shape(input shape_kind_e k, input int x0, input int y0,
                             input int x1, input int y1, input int r, input int ci);
        scene[n_shapes] = '{kind: k, x0: coord_t'(x0), y0: coord_t'(y0), x1: coord_t'(x1),
                            y1: coord_t'(y1), r: coord_t'(r), cidx: cidx_t'(ci)};
        n_shapes++;
    endtask

    // castle without roofs, drawn in this order
    task automatic load_scene();
        add_shape(RECT,    60,  70, 190, 120,  0, 5);
        add_shape(RECT,   110, 100, 140, 120,  0, 4);
        add_shape(CIRCLE, 125, 100,   0,   0, 15, 4);
        add_shape(RECT,    40,  45,  60, 120,  0, 5);
        add_shape(RECT,   110,  40, 140,  70,  0, 5);
        add_shape(RECT,   190,  45, 210, 120,  0, 5);
        add_shape(RECT,    46,  50,  54,  65,  0, 1);
        add_shape(RECT,   120,  45, 130,  65,  0, 1);
        add_shape(RECT,   196,  50, 204,  65,  0, 1);
        add_shape(RECT,    63,  62,  72,  70,  0, 5);
        add_shape(RECT,    80,  62,  89,  70,  0, 5);
        add_shape(RECT,    97,  62, 106,  70,  0, 5);
        add_shape(RECT,   144,  62, 153,  70,  0, 5);
        add_shape(RECT,   161,  62, 170,  70,  0, 5);
        add_shape(RECT,   178,  62, 187,  70,  0, 5);
        add_shape(CIRCLE, 275,  38,   0,   0, 20, 9);  // sun
    endtask

    task automatic push_pixel(input int x, input int y, input cidx_t c);
        exp_q.push_back('{x: coord_t'(x), y: coord_t'(y), cidx: c});
    endtask

    // raster order: rows top to bottom, left to right
    task automatic build_expected();
        int r;
        for (int i = 0; i < `SCENE_SHAPES; i++) begin
            r = int'(scene[i].r);
            if (scene[i].kind == RECT) begin
                for (int y = scene[i].y0; y <= scene[i].y1; y++) begin
                    for (int x = scene[i].x0; x <= scene[i].x1; x++) begin
                        push_pixel(x, y, scene[i].cidx);
                    end
                end
            end else begin
                for (int dy = -r; dy <= r; dy++) begin
                    for (int dx = -r; dx <= r; dx++) begin
                        if (dx * dx + dy * dy <= r * r) begin
                            push_pixel(scene[i].x0 + dx, scene[i].y0 + dy, scene[i].cidx);
                        end
                    end
                end
            end
        end
    endtask

    function automatic int circle_points(input int r);
        int n;
        n = 0;
        for (int dy = -r; dy <= r; dy++) begin
            for (int dx = -r; dx <= r; dx++) begin
                if (dx * dx + dy * dy <= r * r) begin
                    n++;
                end
            end
        end
        return n;
    endfunction

    // one scene from start to done, restart_at > 0 pulses start again mid-scene
    task automatic run_scene(input bit random_ready, input int restart_at);
        int idx;
        int cycles;
        bit got_done;
        idx       = 0;
        cycles    = 0;
        got_done  = 1'b0;
        sun_seen  = 0;
        start     <= 1'b1;
        pix_ready <= 1'b1;
        while (!got_done) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout: no done within %0d cycles of start", TIMEOUT);
                fail_run();
            end
            if (cycles > 1) begin
                check_bit("busy", busy, 1'b1);
            end
            if (pix_valid && pix_ready) begin
                if (idx >= exp_q.size()) begin
                    $display("more pixels arrived than the scene holds");
                    fail_run();
                end
                check_pixel("pix", pix, exp_q[idx]);
                if (pix.cidx == cidx_t'(9)) begin
                    sun_seen++;
                end
                idx++;
            end
            if (done) begin
                check_count("pixel count at done", idx, exp_q.size());
                got_done = 1'b1;
            end
            start     <= (cycles == restart_at);
            pix_ready <= random_ready ? (($urandom & 32'd1) == 32'd1) : 1'b1;
        end
        @(posedge clk);  // done is a single pulse, busy drops with it
        check_idle();
    endtask

    task automatic test_reset();
        rst       <= 1'b1;
        start     <= 1'b0;
        pix_ready <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_idle();
            end
        end
        rst <= 1'b0;
        repeat (50) begin
            @(posedge clk);
            check_idle();
        end
    endtask

    task automatic test_full_scene();
        run_scene(1'b0, 0);
    endtask

    task automatic test_backpressure();
        run_scene(1'b1, 0);
    endtask

    task automatic test_start_while_busy();
        run_scene(1'b1, 4000);  // second start lands mid-scene
        run_scene(1'b0, 0);
    endtask

    task automatic test_sun_colour();
        run_scene(1'b0, 0);
        check_count("sun pixels", sun_seen, circle_points(20));
    endtask

    initial begin
        void'($urandom(692));
        load_scene();
        build_expected();
        test_reset();
        test_full_scene();
        test_backpressure();
        test_start_while_busy();
        test_sun_colour();
        if (dut.u_asserts.fail_count != 0) begin
            $display("%0d output stream assertions failed during the run",
                     dut.u_asserts.fail_count);
            fail_run();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

/* files.f */
+incdir+design
design/gfx_types_pkg.sv
design/draw_cmd_pkg.sv
design/draw_rect_fill.sv
design/draw_circle_fill.sv
design/scene_sequencer.sv
design/scene_renderer.sv
test/scene_renderer_asserts.sv
test/tb_scene_renderer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the scene renderer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    -f files.f \
    --top-module tb_scene_renderer \
    -o tb_scene_renderer

# the log decides the result, so a failing run must not stop the script here
./obj_dir/tb_scene_renderer > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail"
    exit 1
fi
